//--- build.f
+incdir+src
src/fdc_pkg.sv
src/bus_decode.sv
src/sector_buffer.sv
src/wav_player.sv
src/console_tx.sv
src/loader_regs.sv
src/read_return.sv
src/fdc_periph_top.sv
verif/tb_fdc_periph.sv

//--- run.sh
#!/bin/sh
# build with verilator and run, exit status follows the testbench
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f build.f --top-module tb_fdc_periph \
        -o tb_fdc_periph &&
    ./obj_dir/tb_fdc_periph ||
    { echo "simulation failed"; exit 1; }

//--- verif/tb_fdc_periph.sv
`default_nettype none

`include "fdc_params.svh"

module tb_fdc_periph;
    timeunit 1ns;
    timeprecision 100ps;

    // i/o page ports
    localparam logic [15:0] A_TXD    = {`FDC_IO_BASE_HI, 8'd4};
    localparam logic [15:0] A_CTL    = {`FDC_IO_BASE_HI, 8'd6};
    localparam logic [15:0] A_OSD    = {`FDC_IO_BASE_HI, 8'd22};
    localparam logic [15:0] A_PAGE   = {`FDC_IO_BASE_HI, 8'd24};
    localparam logic [15:0] A_ADDR   = {`FDC_IO_BASE_HI, 8'd26};
    localparam logic [15:0] A_DATA   = {`FDC_IO_BASE_HI, 8'd28};
    localparam logic [15:0] A_WAVCTL = {`FDC_IO_BASE_HI, 8'd30};
    localparam logic [15:0] A_PARK   = 16'h0000;       // unmapped address keeps the bus free
    localparam int BUSY_CYC    = 12;                   // uart busy window
    localparam int ACCEPT_CYC  = 3;                    // send must stay up this long
    localparam int TIMEOUT_CYC = 3 * (8 * 1024 + 2000);

    logic                       clk         = 1'b0;
    logic                       reset_n     = 1'b0;
    logic [`FDC_ADDR_W-1:0]     i_cpu_addr  = '0;
    logic                       i_cpu_rd    = 1'b0;
    logic [1:0]                 i_cpu_wr    = 2'b00;
    logic [`FDC_DATA_W-1:0]     i_cpu_wdata = '0;
    logic                       i_uart_busy = 1'b0;
    logic [`FDC_DATA_W-1:0]     o_cpu_rdata;
    logic                       o_uart_send;
    logic [7:0]                 o_uart_data;
    logic [7:0]                 o_osd_command;
    logic                       o_rom_hold;
    logic [`FDC_ROM_PAGE_W-1:0] o_rom_page;
    logic [`FDC_DATA_W-1:0]     o_rom_addr;
    logic [7:0]                 o_rom_data;
    logic                       o_rom_wr;
    logic [7:0]                 o_wav_sample;

    logic [31:0] lfsr = 32'h548a_bdb9;
    logic [7:0]  mem_model [1024];                      // expected buffer bytes
    logic [7:0]  last_sample;
    logic        send_q       = 1'b0;
    int          send_rises   = 0;
    int          busy_cnt     = 0;
    int          accept_cnt   = 0;
    int          rom_wr_count = 0;
    int          cycles       = 0;

    fdc_periph_top u_dut (.clk, .reset_n, .i_cpu_addr, .i_cpu_rd, .i_cpu_wr, .i_cpu_wdata,
        .o_cpu_rdata, .i_uart_busy, .o_uart_send, .o_uart_data, .o_osd_command,
        .o_rom_hold, .o_rom_page, .o_rom_addr, .o_rom_data, .o_rom_wr, .o_wav_sample);

    always #4 clk = ~clk;                               // 8 ns period

    //////////////////////////////
    // uart model and monitors
    //////////////////////////////

    always @(negedge clk)
    begin
        send_q <= o_uart_send;
        if (o_uart_send && !send_q)
            send_rises <= send_rises + 1;
        if (busy_cnt != 0)
        begin
            busy_cnt <= busy_cnt - 1;
            if (busy_cnt == 1)
                i_uart_busy <= 1'b0;                    // byte shifted out
        end
        else if (o_uart_send && !i_uart_busy)
        begin
            if (accept_cnt == ACCEPT_CYC - 1)
            begin
                i_uart_busy <= 1'b1;                    // uart takes the byte
                busy_cnt    <= BUSY_CYC;
                accept_cnt  <= 0;
            end
            else
                accept_cnt <= accept_cnt + 1;
        end
        else
            accept_cnt <= 0;                            // send dropped too early
    end

    always @(negedge clk)
    begin
        if (o_rom_wr)
            rom_wr_count <= rom_wr_count + 1;           // high cycles of the pulse
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC)
        begin
            $display("TEST FAILED");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYC);
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1
    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [15:0] buf_addr(input logic [9:0] a);
        return {`FDC_BUF_PAGE, 2'b00, a};
    endfunction

    function automatic logic [15:0] model_word(input logic [9:0] a);
        return {mem_model[{a[9:1], 1'b1}], mem_model[{a[9:1], 1'b0}]};
    endfunction

    task automatic model_write(input logic [9:0] a, input logic [1:0] lanes,
                               input logic [15:0] data);
        if (lanes[0])
            mem_model[{a[9:1], 1'b0}] = data[7:0];     // even byte
        if (lanes[1])
            mem_model[{a[9:1], 1'b1}] = data[15:8];
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // one-cycle write then park the address
    task automatic cpu_write(input logic [15:0] addr, input logic [1:0] lanes,
                             input logic [15:0] data);
        @(negedge clk);
        i_cpu_addr  = addr;
        i_cpu_wr    = lanes;
        i_cpu_wdata = data;
        @(negedge clk);
        i_cpu_wr   = 2'b00;
        i_cpu_addr = A_PARK;
        check_eq("o_cpu_rdata", 32'(o_cpu_rdata), 32'h0);  // gated to zero without a read
    endtask

    task automatic cpu_read(input logic [15:0] addr, output logic [15:0] data);
        @(negedge clk);
        i_cpu_addr = addr;
        i_cpu_rd   = 1'b1;
        @(negedge clk);
        i_cpu_rd   = 1'b0;
        i_cpu_addr = A_PARK;
        data       = o_cpu_rdata;                       // valid the cycle after
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_buffer();
        logic [9:0]  a;
        logic [1:0]  lanes;
        logic [15:0] w;
        logic [15:0] rd;
        for (int n = 0; n < 32; n++)
        begin
            a = 10'(take_bits(10));
            w = 16'(take_bits(16));
            cpu_write(buf_addr(a), 2'b11, w);
            model_write(a, 2'b11, w);
            lanes = 2'(take_bits(2));
            if (lanes == 2'b00)
                lanes = 2'b01;
            w = 16'(take_bits(16));
            cpu_write(buf_addr(a), lanes, w);           // partial overwrite
            model_write(a, lanes, w);
            cpu_read(buf_addr(a ^ 10'd1), rd);          // other byte of the same word
            check_eq("o_cpu_rdata", 32'(rd), 32'(model_word(a)));
            @(negedge clk);
            check_eq("o_cpu_rdata", 32'(o_cpu_rdata), 32'h0);
        end
    endtask

    task automatic test_loader();
        logic [15:0] w;
        int          base;
        w = 16'(take_bits(16));
        cpu_write(A_PAGE, 2'b01, w);
        check_eq("o_rom_page", 32'(o_rom_page), 32'(w[5:0]));
        w = 16'(take_bits(16));
        cpu_write(A_ADDR, 2'b11, w);
        check_eq("o_rom_addr", 32'(o_rom_addr), 32'(w));
        w = 16'(take_bits(16));
        cpu_write(A_ADDR + 16'd1, 2'b10, w);            // word port through the high lane alone
        check_eq("o_rom_addr", 32'(o_rom_addr), 32'(w));
        for (int n = 0; n < 4; n++)
        begin
            base = rom_wr_count;
            w    = 16'(take_bits(16));
            cpu_write(A_DATA, 2'b01, w);
            check_eq("o_rom_wr", 32'(o_rom_wr), 32'h1);
            check_eq("o_rom_data", 32'(o_rom_data), 32'(w[7:0]));
            @(negedge clk);
            check_eq("o_rom_wr", 32'(o_rom_wr), 32'h0);
            check_eq("o_rom_wr pulse count", 32'(rom_wr_count - base), 32'h1);
        end
        cpu_write(A_OSD, 2'b01, 16'h0008);
        check_eq("o_osd_command", 32'(o_osd_command), 32'h08);
        check_eq("o_rom_hold", 32'(o_rom_hold), 32'h1);
    endtask

    task automatic test_console();
        logic [15:0] w;
        logic [15:0] rd;
        int          base;
        for (int n = 0; n < 2; n++)
        begin
            base = send_rises;
            w    = 16'(take_bits(16));
            cpu_write(A_TXD, 2'b01, w);
            while (!o_uart_send)
                @(negedge clk);
            check_eq("o_uart_data", 32'(o_uart_data), 32'(w[7:0]));
            while (o_uart_send)
                @(negedge clk);
            check_eq("i_uart_busy", 32'(i_uart_busy), 32'h1);  // send drops on busy
            cpu_read(A_CTL, rd);
            check_eq("o_cpu_rdata", 32'(rd), 32'h1);
            while (i_uart_busy)
                @(negedge clk);
            repeat (2) @(negedge clk);
            cpu_read(A_CTL, rd);
            check_eq("o_cpu_rdata", 32'(rd), 32'h0);
            check_eq("o_uart_send rise count", 32'(send_rises - base), 32'h1);
        end
    endtask

    // fill the buffer and follow half 0 from byte 1
    task automatic test_playback(input logic rate, input logic with_reads);
        logic [7:0]  prev;
        logic [7:0]  b;
        logic [15:0] rd;
        logic [9:0]  a;
        logic [10:0] k;
        int          period;
        int          t_last;
        period = rate ? 2 ** (`FDC_WAV_DIV_LOG2 + 1) : 2 ** `FDC_WAV_DIV_LOG2;
        t_last = 0;
        cpu_write(A_WAVCTL, 2'b01, 16'h0000);           // stop and rewind
        repeat (4) @(negedge clk);                      // let a late fetch land
        last_sample = o_wav_sample;
        prev        = last_sample;
        for (k = 11'd0; k < 11'd1024; k++)
        begin
            b = 8'(take_bits(8));
            if (k == 11'd1)
                prev = last_sample;                     // byte 1 plays first
            if (k != 11'd0 && b == prev)
                b = b + 8'd1;                           // every played byte shows a change
            mem_model[k[9:0]] = b;
            prev = b;
        end
        for (k = 11'd0; k < 11'd512; k++)
            cpu_write(buf_addr({k[8:0], 1'b0}), 2'b11, model_word({k[8:0], 1'b0}));
        cpu_write(A_WAVCTL, 2'b01, {13'd0, rate, 2'b01});  // half 0 with enable
        cpu_read(A_WAVCTL, rd);
        check_eq("o_cpu_rdata", 32'(rd), 32'h1);
        for (k = 11'd1; k <= 11'd8; k++)
        begin
            while (o_wav_sample == last_sample)
            begin
                if (with_reads)
                begin
                    a = 10'(take_bits(10));
                    cpu_read(buf_addr(a), rd);          // contend for the buffer
                    check_eq("o_cpu_rdata", 32'(rd), 32'(model_word(a)));
                end
                else
                    @(negedge clk);
            end
            check_eq("o_wav_sample", 32'(o_wav_sample), 32'(mem_model[k[9:0]]));
            // sample spacing to the nearest 64 cycles
            if (k >= 11'd2)
                check_eq("o_wav_sample interval", 32'((cycles - t_last + 32) / 64),
                         32'(period / 64));
            t_last      = cycles;
            last_sample = o_wav_sample;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        check_eq("o_uart_send", 32'(o_uart_send), 32'h0);
        check_eq("o_rom_wr", 32'(o_rom_wr), 32'h0);
        check_eq("o_osd_command", 32'(o_osd_command), 32'h0);
        check_eq("o_rom_hold", 32'(o_rom_hold), 32'h0);
        check_eq("o_wav_sample", 32'(o_wav_sample), 32'h0);
        check_eq("o_cpu_rdata", 32'(o_cpu_rdata), 32'h0);
        test_buffer();
        test_loader();
        test_console();
        test_playback(1'b0, 1'b0);                      // 48 kHz on a quiet bus
        test_playback(1'b1, 1'b1);                      // 24 kHz with cpu reads
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/fdc_periph_top.sv
`default_nettype none

`include "fdc_params.svh"

module fdc_periph_top import fdc_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic [`FDC_ADDR_W-1:0]     i_cpu_addr,
    input  logic                       i_cpu_rd,
    input  logic [1:0]                 i_cpu_wr,
    input  logic [`FDC_DATA_W-1:0]     i_cpu_wdata,
    output logic [`FDC_DATA_W-1:0]     o_cpu_rdata,
    input  logic                       i_uart_busy,
    output logic                       o_uart_send,
    output logic [7:0]                 o_uart_data,
    output logic [7:0]                 o_osd_command,
    output logic                       o_rom_hold,
    output logic [`FDC_ROM_PAGE_W-1:0] o_rom_page,
    output logic [`FDC_DATA_W-1:0]     o_rom_addr,
    output logic [7:0]                 o_rom_data,
    output logic                       o_rom_wr,
    output logic [7:0]                 o_wav_sample
);

    logic                   buf_rd, io_rd, bus_free, wav_rd;
    logic [1:0]             buf_wr, wav_ctl;
    io_port_e               sel_port;
    logic                   wavctl_wr, txd_wr, osdcmd_wr;
    logic                   rom_page_wr, rom_addr_wr, rom_data_wr;
    logic [`FDC_BUF_AW-1:0] wav_addr;
    logic [`FDC_DATA_W-1:0] buf_rdata;
    logic [7:0]             buf_byte;

    // decode
    bus_decode u_decode (.clk, .reset_n, .i_cpu_addr, .i_cpu_rd, .i_cpu_wr,
        .o_buf_rd(buf_rd), .o_buf_wr(buf_wr), .o_io_rd(io_rd), .o_sel_port(sel_port),
        .o_wavctl_wr(wavctl_wr), .o_txd_wr(txd_wr), .o_osdcmd_wr(osdcmd_wr),
        .o_rom_page_wr(rom_page_wr), .o_rom_addr_wr(rom_addr_wr),
        .o_rom_data_wr(rom_data_wr), .o_bus_free(bus_free));

    // execute
    sector_buffer u_buffer (.clk, .i_buf_rd(buf_rd), .i_buf_wr(buf_wr), .i_cpu_addr,
        .i_cpu_wdata, .i_wav_rd(wav_rd), .i_wav_addr(wav_addr),
        .o_buf_rdata(buf_rdata), .o_buf_byte(buf_byte));

    wav_player u_wav (.clk, .reset_n, .i_wavctl_wr(wavctl_wr), .i_cpu_wdata,
        .i_bus_free(bus_free), .i_buf_byte(buf_byte), .o_wav_rd(wav_rd),
        .o_wav_addr(wav_addr), .o_wav_ctl(wav_ctl), .o_wav_sample);

    console_tx u_console (.clk, .reset_n, .i_txd_wr(txd_wr), .i_cpu_wdata, .i_uart_busy,
        .o_uart_send, .o_uart_data);

    loader_regs u_loader (.clk, .reset_n, .i_osdcmd_wr(osdcmd_wr),
        .i_rom_page_wr(rom_page_wr), .i_rom_addr_wr(rom_addr_wr),
        .i_rom_data_wr(rom_data_wr), .i_cpu_wdata, .o_osd_command, .o_rom_hold,
        .o_rom_page, .o_rom_addr, .o_rom_data, .o_rom_wr);

    // result
    read_return u_return (.clk, .reset_n, .i_buf_rd(buf_rd), .i_io_rd(io_rd),
        .i_sel_port(sel_port), .i_buf_rdata(buf_rdata), .i_uart_busy,
        .i_wav_ctl(wav_ctl), .o_cpu_rdata);

endmodule

`default_nettype wire

//--- src/read_return.sv
`default_nettype none

`include "fdc_params.svh"

module read_return import fdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   i_buf_rd,
    input  logic                   i_io_rd,
    input  io_port_e               i_sel_port,      // already one cycle late
    input  logic [`FDC_DATA_W-1:0] i_buf_rdata,
    input  logic                   i_uart_busy,
    input  logic [1:0]             i_wav_ctl,
    output logic [`FDC_DATA_W-1:0] o_cpu_rdata
);

    logic                   buf_rd_q;
    logic                   io_rd_q;
    logic [`FDC_DATA_W-1:0] port_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            buf_rd_q <= 1'b0;
            io_rd_q  <= 1'b0;
        end
        else
        begin
            buf_rd_q <= i_buf_rd;
            io_rd_q  <= i_io_rd;
        end
    end

    // readable ports, rest read zero
    always_comb
    begin
        case (i_sel_port)
            PORT_CTL:    port_data = {{(`FDC_DATA_W-1){1'b0}}, i_uart_busy};
            PORT_WAVCTL: port_data = {{(`FDC_DATA_W-2){1'b0}}, i_wav_ctl};
            default:     port_data = '0;
        endcase
    end

    // zero unless a read went out last cycle
    assign o_cpu_rdata = buf_rd_q ? i_buf_rdata :
                         io_rd_q  ? port_data   : '0;

endmodule

`default_nettype wire

//--- src/loader_regs.sv
`default_nettype none

`include "fdc_params.svh"

module loader_regs
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_osdcmd_wr,
    input  logic                      i_rom_page_wr,
    input  logic                      i_rom_addr_wr,
    input  logic                      i_rom_data_wr,
    input  logic [`FDC_DATA_W-1:0]    i_cpu_wdata,
    output logic [7:0]                o_osd_command,
    output logic                      o_rom_hold,
    output logic [`FDC_ROM_PAGE_W-1:0] o_rom_page,
    output logic [`FDC_DATA_W-1:0]    o_rom_addr,
    output logic [7:0]                o_rom_data,
    output logic                      o_rom_wr
);

    // loader byte, valid with o_rom_wr
    always_ff @(posedge clk)
    begin
        if (i_rom_data_wr)
            o_rom_data <= i_cpu_wdata[7:0];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            o_osd_command <= '0;
            o_rom_page    <= '0;
            o_rom_addr    <= '0;
            o_rom_wr      <= 1'b0;
        end
        else
        begin
            o_rom_wr <= i_rom_data_wr;          // one pulse per data write
            if (i_osdcmd_wr)
                o_osd_command <= i_cpu_wdata[7:0];
            if (i_rom_page_wr)
                o_rom_page <= i_cpu_wdata[`FDC_ROM_PAGE_W-1:0];
            if (i_rom_addr_wr)
                o_rom_addr <= i_cpu_wdata;      // whole word
        end
    end

    assign o_rom_hold = o_osd_command[3];       // stalls host while loading

endmodule

`default_nettype wire

//--- src/console_tx.sv
`default_nettype none

`include "fdc_params.svh"

module console_tx import fdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   i_txd_wr,
    input  logic [`FDC_DATA_W-1:0] i_cpu_wdata,
    input  logic                   i_uart_busy,
    output logic                   o_uart_send,
    output logic [7:0]             o_uart_data
);

    con_state_e state;

    // byte latch, only meaningful while sending
    always_ff @(posedge clk)
    begin
        if (i_txd_wr)
            o_uart_data <= i_cpu_wdata[7:0];
    end

    //////////////////////////////
    // send / busy handshake
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state       <= CON_IDLE;
            o_uart_send <= 1'b0;
        end
        else if (i_txd_wr)
            state <= CON_ARM;                   // new byte, start over
        else
        begin
            case (state)
                CON_ARM:
                    if (!i_uart_busy)
                    begin
                        o_uart_send <= 1'b1;
                        state       <= CON_SENT;
                    end
                CON_SENT:
                    if (i_uart_busy)
                    begin
                        o_uart_send <= 1'b0;    // uart took it
                        state       <= CON_DRAIN;
                    end
                CON_DRAIN:
                    if (!i_uart_busy)
                        state <= CON_IDLE;      // shifted out
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/wav_player.sv
`default_nettype none

`include "fdc_params.svh"

module wav_player import fdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   i_wavctl_wr,
    input  logic [`FDC_DATA_W-1:0] i_cpu_wdata,
    input  logic                   i_bus_free,
    input  logic [7:0]             i_buf_byte,
    output logic                   o_wav_rd,
    output logic [`FDC_BUF_AW-1:0] o_wav_addr,
    output logic [1:0]             o_wav_ctl,
    output logic [7:0]             o_wav_sample
);

    logic [`FDC_WAV_DIV_LOG2:0]   div_q;            // one extra bit for the slow rate
    logic [2:0]                   ctl_q;            // {rate, half, enable}
    logic [`FDC_BUF_AW-2:0]       pos_q;            // position inside a half
    logic [`FDC_BUF_AW-2:0]       pos_next;
    logic                         tick;
    logic                         tick_fast;
    logic                         tick_slow;
    wav_rd_e                      rd_state;

    //////////////////////////////
    // rate divider
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            div_q <= '0;
        else
            div_q <= div_q + 1'b1;      // free running
    end

    assign tick_fast = &div_q[`FDC_WAV_DIV_LOG2-1:0];
    assign tick_slow = &div_q;
    assign tick      = ctl_q[2] ? tick_slow : tick_fast;    // rate bit set -> 24 kHz

    assign pos_next = pos_q + 1'b1;

    //////////////////////////////
    // position, half and fetch
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ctl_q        <= '0;
            pos_q        <= '0;
            rd_state     <= WRD_IDLE;
            o_wav_sample <= '0;
        end
        else
        begin
            if (tick && ctl_q[0])
            begin
                pos_q    <= pos_next;
                rd_state <= WRD_REQ;            // new tick restarts any fetch
                if (pos_next == '0)
                    ctl_q[1] <= ~ctl_q[1];      // swap ping-pong half
            end
            else
            begin
                case (rd_state)
                    WRD_REQ:
                        if (i_bus_free)
                            rd_state <= WRD_CAPTURE;
                    WRD_CAPTURE:
                    begin
                        o_wav_sample <= i_buf_byte;     // byte read last cycle
                        rd_state     <= WRD_IDLE;
                    end
                    default: ;
                endcase
            end

            // start / stop, also rewinds
            if (i_wavctl_wr)
            begin
                ctl_q <= i_cpu_wdata[2:0];
                pos_q <= '0;
            end
        end
    end

    assign o_wav_rd   = (rd_state == WRD_REQ) & i_bus_free;
    assign o_wav_addr = {ctl_q[1], pos_q};
    assign o_wav_ctl  = ctl_q[1:0];             // half, enable for readback

endmodule

`default_nettype wire

//--- src/sector_buffer.sv
`default_nettype none

`include "fdc_params.svh"

module sector_buffer
(
    input  logic                   clk,
    input  logic                   i_buf_rd,
    input  logic [1:0]             i_buf_wr,
    input  logic [`FDC_ADDR_W-1:0] i_cpu_addr,
    input  logic [`FDC_DATA_W-1:0] i_cpu_wdata,
    input  logic                   i_wav_rd,
    input  logic [`FDC_BUF_AW-1:0] i_wav_addr,
    output logic [`FDC_DATA_W-1:0] o_buf_rdata,
    output logic [7:0]             o_buf_byte
);

    localparam int WORDS = 2 ** (`FDC_BUF_AW - 1);

    logic                   cpu_sel;                // cpu owns the buffer
    logic                   mem_cs;
    logic [`FDC_BUF_AW-1:0] mem_addr;
    logic [`FDC_BUF_AW-2:0] word;
    logic                   a0_q;                   // lane for the player byte
    logic [7:0]             lane_q [2];

    assign cpu_sel  = i_buf_rd | (|i_buf_wr);
    assign mem_cs   = cpu_sel | i_wav_rd;
    assign mem_addr = cpu_sel ? i_cpu_addr[`FDC_BUF_AW-1:0] : i_wav_addr;   // cpu wins
    assign word     = mem_addr[`FDC_BUF_AW-1:1];

    //////////////////////////////
    // byte lanes, lane 0 = even bytes
    //////////////////////////////

    for (genvar ln = 0; ln < 2; ln++)
    begin : g_lane
        logic [7:0] mem [WORDS];

        always_ff @(posedge clk)
        begin
            if (mem_cs)
            begin
                if (i_buf_wr[ln])
                    mem[word] <= i_cpu_wdata[8*ln +: 8];
                lane_q[ln] <= mem[word];            // sync read
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_cs)
            a0_q <= mem_addr[0];
    end

    assign o_buf_rdata = {lane_q[1], lane_q[0]};
    assign o_buf_byte  = a0_q ? lane_q[1] : lane_q[0];     // odd address -> high lane

    // player only reads when decode reports a free bus
    a_no_share: assert property (@(posedge clk)
        !(i_wav_rd && (i_buf_rd || (|i_buf_wr))));

endmodule

`default_nettype wire

//--- src/bus_decode.sv
`default_nettype none

`include "fdc_params.svh"

module bus_decode import fdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [`FDC_ADDR_W-1:0] i_cpu_addr,
    input  logic                   i_cpu_rd,
    input  logic [1:0]             i_cpu_wr,
    output logic                   o_buf_rd,
    output logic [1:0]             o_buf_wr,
    output logic                   o_io_rd,
    output io_port_e               o_sel_port,
    output logic                   o_wavctl_wr,
    output logic                   o_txd_wr,
    output logic                   o_osdcmd_wr,
    output logic                   o_rom_page_wr,
    output logic                   o_rom_addr_wr,
    output logic                   o_rom_data_wr,
    output logic                   o_bus_free
);

    localparam logic [7:0] ROM_ADDR_OFS = PORT_ROM_ADDR;    // for the word match

    region_e    region;
    logic [7:0] port_ofs;
    logic       io_wr0;                                    // byte port write
    logic       buf_sel;

    assign port_ofs = i_cpu_addr[7:0];

    // region from the upper address bits
    always_comb
    begin
        if (i_cpu_addr[15:12] == `FDC_BUF_PAGE)
            region = REG_BUF;
        else if (i_cpu_addr[15:8] == `FDC_IO_BASE_HI)
            region = REG_IO;
        else
            region = REG_NONE;
    end

    assign buf_sel  = (region == REG_BUF);
    assign o_buf_rd = buf_sel & i_cpu_rd;
    assign o_buf_wr = {2{buf_sel}} & i_cpu_wr;
    assign o_io_rd  = (region == REG_IO) & i_cpu_rd;

    assign io_wr0   = (region == REG_IO) & i_cpu_wr[0];

    // one strobe per port
    assign o_txd_wr      = io_wr0 & (port_ofs == PORT_TXD);
    assign o_osdcmd_wr   = io_wr0 & (port_ofs == PORT_OSD_CMD);
    assign o_rom_page_wr = io_wr0 & (port_ofs == PORT_ROM_PAGE);
    assign o_rom_data_wr = io_wr0 & (port_ofs == PORT_ROM_DATA);
    assign o_wavctl_wr   = io_wr0 & (port_ofs == PORT_WAVCTL);
    // word port, either lane, bit 0 ignored
    assign o_rom_addr_wr = (region == REG_IO) & (|i_cpu_wr)
                         & (port_ofs[7:1] == ROM_ADDR_OFS[7:1]);

    // player may use the buffer only when cpu is quiet
    assign o_bus_free = ~(i_cpu_rd | (|i_cpu_wr) | buf_sel);

    // port select for the result stage, one cycle late
    always_ff @(posedge clk)
    begin
        o_sel_port <= io_port_e'(port_ofs);
    end

    a_one_port_wr: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({o_txd_wr, o_osdcmd_wr, o_rom_page_wr, o_rom_addr_wr,
                  o_rom_data_wr, o_wavctl_wr}));

endmodule

`default_nettype wire

//--- src/fdc_pkg.sv
`default_nettype none

package fdc_pkg;

    // region hit by a cpu access
    typedef enum logic [1:0]
    {
        REG_NONE,                   // nothing mapped here
        REG_BUF,                    // sector buffer window
        REG_IO                      // i/o page
    } region_e;

    // port offsets in the i/o page
    typedef enum logic [7:0]
    {
        PORT_TXD      = 8'd4,       // console byte, write only
        PORT_CTL      = 8'd6,       // uart busy in bit 0
        PORT_OSD_CMD  = 8'd22,      // {romhold, f11, f12, hold}
        PORT_ROM_PAGE = 8'd24,      // loader address 21:16
        PORT_ROM_ADDR = 8'd26,      // loader address 15:0, word port
        PORT_ROM_DATA = 8'd28,      // loader byte, makes the write pulse
        PORT_WAVCTL   = 8'd30       // sound control
    } io_port_e;

    // sound sample fetch
    typedef enum logic [1:0]
    {
        WRD_IDLE,                   // nothing pending
        WRD_REQ,                    // waiting for a free bus
        WRD_CAPTURE                 // buffer byte valid this cycle
    } wav_rd_e;

    // console transmit sequencer
    typedef enum logic [1:0]
    {
        CON_ARM,                    // byte latched, wait for idle uart
        CON_SENT,                   // send high until busy
        CON_DRAIN,                  // wait for busy to drop
        CON_IDLE
    } con_state_e;

endpackage

`default_nettype wire

//--- src/fdc_params.svh
`ifndef FDC_PARAMS_SVH
`define FDC_PARAMS_SVH

//////////////////////////////
// cpu bus
//////////////////////////////

`define FDC_ADDR_W        16        // byte address
`define FDC_DATA_W        16        // word data, two byte lanes

//////////////////////////////
// address map
//////////////////////////////

// i/o page $ff00..$ffff, port offset in the low byte
`define FDC_IO_BASE_HI    8'hFF

// sector buffer window $d000..$dfff, only 1 KB decoded
`define FDC_BUF_PAGE      4'hD
`define FDC_BUF_AW        10        // byte address into the buffer

//////////////////////////////
// sound player
//////////////////////////////

// tick every 512 clocks for the fast rate
// slow rate uses one more divider bit
`define FDC_WAV_DIV_LOG2  9

//////////////////////////////
// rom loader
//////////////////////////////

`define FDC_ROM_PAGE_W    6         // upper loader address bits

`endif
